// File: mips_cpu_harvard.f
verilog/mips_pkg.sv
verilog/mips_control.sv
verilog/mips_regfile.sv
verilog/mips_alu.sv
verilog/mips_fetch.sv
verilog/mips_cpu_harvard.sv
tests/mips_cpu_assertions.sv
tests/mips_checker.sv
tests/mips_cpu_harvard_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert --timescale 1ns/1ps
TOP       = mips_cpu_harvard_tb
FILELIST  = mips_cpu_harvard.f
OBJ_DIR   = obj_dir
PASS_MSG  = Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: tests/mips_cpu_harvard_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mips_cpu_harvard_tb;

	logic        clk = 1'b0;   // Low from the start so time zero has no edge
	logic        reset;
	logic        clk_enable;
	logic [31:0] instr_readdata;
	logic [31:0] data_readdata;
	logic        active;
	logic [31:0] register_v0;
	logic [31:0] instr_address;
	logic [31:0] data_address;
	logic        data_write;
	logic        data_read;
	logic [31:0] data_writedata;
	logic [31:0] dmem [256];   // Word index from address bits 9:2
	integer      seed;
	int          checker_errors;
	int          tb_errors;
	int          retired;      // Instructions retired so far
	int          guard;
	logic        link_valid;   // $31 holds a return address
	logic        cur_links;    // Presented instruction is JAL
	logic [31:0] word;
	logic [31:0] roll;

	mips_cpu_harvard u_dut (.*);

	mips_checker u_checker (.error_count(checker_errors), .*);

	initial begin
		forever #50 clk = ~clk; // 100 ns period
	end

	assign data_readdata = dmem[data_address[9:2]]; // Combinational read

	always @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < 256; i++) begin
				dmem[i] <= 32'h9e3779b9 * (i + 1); // Pattern over whole index
			end
		end else if (data_write) begin
			dmem[data_address[9:2]] <= data_writedata;
		end
	end

	// Random instruction from the subset with destinations biased to $2
	task automatic build_instr(output logic [31:0] w, output logic is_jal);
		logic [31:0] r;
		logic [31:0] s;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		r      = $random(seed);
		s      = $random(seed);
		rs     = {2'b00, r[2:0]};
		rt     = {2'b00, r[5:3]};
		rd     = r[6] ? mips_pkg::V0_REG : {2'b00, r[9:7]};
		is_jal = 1'b0;
		case (s[4:0])
			5'd0:  w = {6'd0, rs, rt, rd, 5'd0, mips_pkg::FN_ADDU};
			5'd1:  w = {6'd0, rs, rt, rd, 5'd0, mips_pkg::FN_SUBU};
			5'd2:  w = {6'd0, rs, rt, rd, 5'd0, mips_pkg::FN_AND};
			5'd3:  w = {6'd0, rs, rt, rd, 5'd0, mips_pkg::FN_OR};
			5'd4:  w = {6'd0, rs, rt, rd, 5'd0, mips_pkg::FN_XOR};
			5'd5:  w = {6'd0, rs, rt, rd, 5'd0, mips_pkg::FN_SLT};
			5'd6:  w = {6'd0, rs, rt, rd, 5'd0, mips_pkg::FN_SLTU};
			5'd7:  w = {6'd0, 5'd0, rt, rd, s[12:8], mips_pkg::FN_SLL};
			5'd8:  w = {6'd0, 5'd0, rt, rd, s[12:8], mips_pkg::FN_SRL};
			5'd10: w = {mips_pkg::OP_SLTI, rs, rd, s[31:16]};
			5'd11: w = {mips_pkg::OP_SLTIU, rs, rd, s[31:16]};
			5'd12: w = {mips_pkg::OP_ANDI, rs, rd, s[31:16]};
			5'd13: w = {mips_pkg::OP_ORI, rs, rd, s[31:16]};
			5'd14: w = {mips_pkg::OP_XORI, rs, rd, s[31:16]};
			5'd15: w = {mips_pkg::OP_LUI, 5'd0, rd, s[31:16]};
			5'd16, 5'd17, 5'd18: w = {mips_pkg::OP_LW, 5'd0, rd, 6'd0, s[15:8], 2'b00};
			5'd19, 5'd20, 5'd21: w = {mips_pkg::OP_SW, 5'd0, rt, 6'd0, s[15:8], 2'b00};
			5'd22: w = {mips_pkg::OP_BEQ, rs, rt, s[31:16]};
			5'd23: w = {mips_pkg::OP_BNE, rs, rt, s[31:16]};
			5'd24: w = {mips_pkg::OP_J, s[31:6]};
			5'd25: begin
				w      = {mips_pkg::OP_JAL, s[31:6]};
				is_jal = 1'b1;
			end
			// Register jumps only through a known link value
			5'd26: w = link_valid ? {6'd0, mips_pkg::LINK_REG, 15'd0, mips_pkg::FN_JR} :
				{mips_pkg::OP_ADDIU, rs, rd, s[31:16]};
			5'd27: w = link_valid ? {6'd0, mips_pkg::LINK_REG, 5'd0, rd, 5'd0, mips_pkg::FN_JALR} :
				{mips_pkg::OP_ADDIU, rs, rd, s[31:16]};
			5'd28: w = {6'b111111, s[31:6]}; // Undefined opcode
			default: w = {mips_pkg::OP_ADDIU, rs, rd, s[31:16]};
		endcase
	endtask

	initial begin
		seed           = 32'hc5c362b4;
		reset          = 1'b1;
		clk_enable     = 1'b0;
		instr_readdata = 32'd0;
		tb_errors      = 0;
		retired        = 0;
		link_valid     = 1'b0;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		build_instr(word, cur_links);
		instr_readdata <= word;
		clk_enable     <= 1'b1;
		guard = 0;
		while (retired < 1500 && guard < 4000) begin
			@(posedge clk);
			guard++;
			if (clk_enable && active) begin // Presented instruction retires here
				retired++;
				link_valid = link_valid || cur_links;
				build_instr(word, cur_links);
				instr_readdata <= word;
			end
			roll = $random(seed);
			clk_enable <= (roll[2:0] != 3'd0); // Stall about one cycle in eight
		end
		if (retired < 1500) begin
			tb_errors++;
			$display("Timeout: only %0d instructions retired", retired);
		end
		instr_readdata <= 32'h00000008; // JR $0
		clk_enable     <= 1'b1;
		guard = 0;
		while (active && guard < 20) begin
			@(negedge clk);
			guard++;
		end
		if (active) begin
			tb_errors++;
			$display("Timeout: active never fell after the jump to zero");
		end
		repeat (16) begin // Halted core must ignore further traffic
			@(posedge clk);
			build_instr(word, cur_links);
			instr_readdata <= word;
		end
		$display("Errors: %0d checker, %0d testbench, %0d assertion",
			checker_errors, tb_errors, u_dut.u_assertions.failures);
		if (checker_errors + tb_errors + u_dut.u_assertions.failures == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tests/mips_checker.sv
`timescale 1ns/1ps
`default_nettype none

module mips_checker (
	input  logic        clk,
	input  logic        reset,
	input  logic        clk_enable,
	input  logic [31:0] instr_readdata,
	input  logic [31:0] instr_address,
	input  logic        active,
	input  logic [31:0] register_v0,
	input  logic [31:0] data_address,
	input  logic        data_write,
	input  logic        data_read,
	input  logic [31:0] data_writedata,
	output int          error_count
);

	logic [31:0] gpr [32];  // Reference registers
	logic [31:0] mem [256]; // Reference data memory
	logic [31:0] pc;
	logic        run;       // Model active
	logic [31:0] cur_instr; // Latched mid-cycle
	logic        cur_en;
	logic        exp_write;
	logic        exp_read;
	logic [31:0] eff_addr;
	int          errors = 0;

	assign error_count = errors;

	task automatic compare_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("FAILED %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// ISA semantics, no delay slot
	task automatic execute_instr(input logic [31:0] w);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] simm;
		logic [31:0] addr;
		logic [31:0] link;
		logic [31:0] npc;
		logic [31:0] val;
		logic [4:0]  dst;
		logic        wr;
		a    = gpr[w[25:21]];
		b    = gpr[w[20:16]];
		simm = {{16{w[15]}}, w[15:0]};
		addr = a + simm;
		link = pc + 32'd4;
		npc  = link;
		val  = 32'd0;
		dst  = w[20:16]; // I-type writes rt
		wr   = 1'b1;
		case (w[31:26])
			mips_pkg::OP_SPECIAL: begin
				dst = w[15:11];
				case (w[5:0])
					mips_pkg::FN_ADDU: val = a + b;
					mips_pkg::FN_SUBU: val = a - b;
					mips_pkg::FN_AND:  val = a & b;
					mips_pkg::FN_OR:   val = a | b;
					mips_pkg::FN_XOR:  val = a ^ b;
					mips_pkg::FN_SLT:  val = {31'd0, $signed(a) < $signed(b)};
					mips_pkg::FN_SLTU: val = {31'd0, a < b};
					mips_pkg::FN_SLL:  val = b << w[10:6];
					mips_pkg::FN_SRL:  val = b >> w[10:6];
					mips_pkg::FN_JR: begin
						wr  = 1'b0;
						npc = a;
					end
					mips_pkg::FN_JALR: begin
						val = link;
						npc = a;
					end
					default: wr = 1'b0;
				endcase
			end
			mips_pkg::OP_ADDIU: val = addr;
			mips_pkg::OP_SLTI:  val = {31'd0, $signed(a) < $signed(simm)};
			mips_pkg::OP_SLTIU: val = {31'd0, a < simm}; // Sign-extended, unsigned compare
			mips_pkg::OP_ANDI:  val = a & {16'h0000, w[15:0]};
			mips_pkg::OP_ORI:   val = a | {16'h0000, w[15:0]};
			mips_pkg::OP_XORI:  val = a ^ {16'h0000, w[15:0]};
			mips_pkg::OP_LUI:   val = {w[15:0], 16'h0000};
			mips_pkg::OP_LW:    val = mem[addr[9:2]];
			mips_pkg::OP_SW: begin
				wr = 1'b0;
				mem[addr[9:2]] = b;
			end
			mips_pkg::OP_BEQ: begin
				wr = 1'b0;
				if (a == b) npc = link + {simm[29:0], 2'b00};
			end
			mips_pkg::OP_BNE: begin
				wr = 1'b0;
				if (a != b) npc = link + {simm[29:0], 2'b00};
			end
			mips_pkg::OP_J: begin
				wr  = 1'b0;
				npc = {pc[31:28], w[25:0], 2'b00};
			end
			mips_pkg::OP_JAL: begin
				dst = mips_pkg::LINK_REG;
				val = link;
				npc = {pc[31:28], w[25:0], 2'b00};
			end
			default: wr = 1'b0; // Undefined opcode is a no-op
		endcase
		if (wr && dst != 5'd0) gpr[dst] = val;
		pc = npc;
		if (npc == 32'd0) run = 1'b0; // Jump to zero halts
	endtask

	always @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				gpr[i] = 32'd0;
			end
			for (int i = 0; i < 256; i++) begin
				mem[i] = 32'h9e3779b9 * (i + 1); // Same fill as the testbench memory
			end
			pc  = mips_pkg::RESET_VECTOR;
			run = 1'b1;
		end else if (cur_en && run) begin
			execute_instr(cur_instr);
		end
	end

	// Outputs settle by mid-cycle
	always @(negedge clk) begin
		cur_instr = instr_readdata;
		cur_en    = clk_enable;
		if (reset) begin
			compare_value("active in reset", {31'd0, active}, 32'd1);
			compare_value("instr_address in reset", instr_address, mips_pkg::RESET_VECTOR);
			compare_value("strobes in reset", {30'd0, data_write, data_read}, 32'd0);
		end else begin
			compare_value("instr_address", instr_address, pc);
			compare_value("register_v0", register_v0, gpr[mips_pkg::V0_REG]);
			compare_value("active", {31'd0, active}, {31'd0, run});
			eff_addr  = gpr[instr_readdata[25:21]] +
				{{16{instr_readdata[15]}}, instr_readdata[15:0]};
			exp_write = clk_enable && run && (instr_readdata[31:26] == mips_pkg::OP_SW);
			exp_read  = clk_enable && run && (instr_readdata[31:26] == mips_pkg::OP_LW);
			compare_value("data_write", {31'd0, data_write}, {31'd0, exp_write});
			compare_value("data_read", {31'd0, data_read}, {31'd0, exp_read});
			if (exp_write) begin
				compare_value("store address", data_address, eff_addr);
				compare_value("store data", data_writedata, gpr[instr_readdata[20:16]]);
			end
			if (exp_read) compare_value("load address", data_address, eff_addr);
		end
	end

endmodule

`default_nettype wire

// File: tests/mips_cpu_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module mips_cpu_assertions (
	input logic        clk,
	input logic        reset,
	input logic        clk_enable,
	input logic        active,
	input logic        data_write,
	input logic        data_read,
	input logic [31:0] instr_address,
	input logic [31:0] register_v0
);

	int failures = 0; // Failed assertion count

	stall_hold: assert property (@(posedge clk) disable iff (reset)
		!clk_enable |=> $stable(instr_address) && $stable(register_v0))
		else begin
			$error("instr_address or register_v0 changed while clk_enable was low");
			failures++;
		end

	halt_quiet: assert property (@(posedge clk) disable iff (reset)
		!active |-> !data_write && !data_read)
		else begin
			$error("Memory strobe after halt");
			failures++;
		end

	halt_sticky: assert property (@(posedge clk) disable iff (reset)
		!active |=> !active)
		else begin
			$error("active rose again after halt");
			failures++;
		end

	halt_pc_hold: assert property (@(posedge clk) disable iff (reset)
		!active |=> $stable(instr_address))
		else begin
			$error("instr_address moved after halt");
			failures++;
		end

endmodule

bind mips_cpu_harvard mips_cpu_assertions u_assertions (
	.clk(clk),
	.reset(reset),
	.clk_enable(clk_enable),
	.active(active),
	.data_write(data_write),
	.data_read(data_read),
	.instr_address(instr_address),
	.register_v0(register_v0)
);

`default_nettype wire

// File: verilog/mips_cpu_harvard.sv
`timescale 1ns/1ps
`default_nettype none

module mips_cpu_harvard (
	input  logic        clk,
	input  logic        reset,
	output logic        active,
	output logic [31:0] register_v0,
	input  logic        clk_enable,
	output logic [31:0] instr_address,
	input  logic [31:0] instr_readdata,
	output logic [31:0] data_address,
	output logic        data_write,
	output logic        data_read,
	output logic [31:0] data_writedata,
	input  logic [31:0] data_readdata
);

	mips_pkg::instr_t instr;
	mips_pkg::ctrl_t  ctrl;
	logic [31:0]      rs_value;
	logic [31:0]      rt_value;
	logic [31:0]      imm_ext;
	logic [31:0]      alu_b;
	logic [31:0]      alu_result;
	logic [31:0]      wb_data;
	logic [31:0]      pc_plus4;
	logic [4:0]       dst_reg;
	logic             equal;
	logic             step;

	assign instr = mips_pkg::instr_t'(instr_readdata);

	mips_control u_control (.instr(instr), .ctrl(ctrl));

	// Zero-extend logic immediates, sign-extend the rest (branches included)
	assign imm_ext = ctrl.imm_zero_ext ? {16'h0000, instr_readdata[15:0]} :
		{{16{instr_readdata[15]}}, instr_readdata[15:0]};

	assign alu_b   = ctrl.alu_imm ? imm_ext : rt_value; // Operand B
	assign dst_reg = ctrl.dst_link ? mips_pkg::LINK_REG :
		(ctrl.dst_rd ? instr.rd : instr.rt);

	always_comb begin
		case (ctrl.wb_sel)
			mips_pkg::WB_MEM:  wb_data = data_readdata; // Same-cycle load
			mips_pkg::WB_LINK: wb_data = pc_plus4;      // No delay slot
			default:           wb_data = alu_result;
		endcase
	end

	mips_regfile u_regfile (
		.clk(clk), .reset(reset),
		.write_en(step && ctrl.reg_write), // Only on retiring edges
		.read_addr_a(instr.rs), .read_addr_b(instr.rt), .write_addr(dst_reg),
		.write_data(wb_data),
		.read_data_a(rs_value), .read_data_b(rt_value), .v0(register_v0)
	);

	mips_alu u_alu (
		.op(ctrl.alu_op), .a(rs_value), .b(alu_b), .shamt(instr.shamt),
		.result(alu_result), .zero(equal)
	);

	mips_fetch u_fetch (
		.clk(clk), .reset(reset), .clk_enable(clk_enable),
		.ctrl(ctrl), .equal(equal), .rs_value(rs_value),
		.imm_ext(imm_ext), .target(instr_readdata[25:0]),
		.pc(instr_address), .pc_plus4(pc_plus4),
		.active(active), .step(step)
	);

	assign data_address   = alu_result; // Effective address
	assign data_writedata = rt_value;
	assign data_write     = step && ctrl.mem_write; // Strobes low when stalled or halted
	assign data_read      = step && ctrl.mem_read;

endmodule

`default_nettype wire

// File: verilog/mips_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module mips_fetch (
	input  logic            clk,
	input  logic            reset,
	input  logic            clk_enable,
	input  mips_pkg::ctrl_t ctrl,
	input  logic            equal,
	input  logic [31:0]     rs_value,
	input  logic [31:0]     imm_ext,
	input  logic [25:0]     target,
	output logic [31:0]     pc,
	output logic [31:0]     pc_plus4,
	output logic            active,
	output logic            step
);

	logic [31:0] pc_next;
	logic [31:0] branch_target;
	logic        take_branch;

	assign step          = clk_enable && active; // Retire qualifier
	assign pc_plus4      = pc + 32'd4;
	assign branch_target = pc_plus4 + {imm_ext[29:0], 2'b00}; // Word offset
	assign take_branch   = (ctrl.branch_eq && equal) || (ctrl.branch_ne && !equal);

	always_comb begin
		if (ctrl.jump_reg) begin
			pc_next = rs_value; // JR / JALR
		end else if (ctrl.jump) begin
			pc_next = {pc[31:28], target, 2'b00}; // Same 256 MB region
		end else if (take_branch) begin
			pc_next = branch_target;
		end else begin
			pc_next = pc_plus4;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pc     <= mips_pkg::RESET_VECTOR;
			active <= 1'b1;
		end else if (step) begin
			pc <= pc_next;
			if (pc_next == 32'd0) begin
				active <= 1'b0; // Jump to zero halts, PC then holds
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/mips_alu.sv
`timescale 1ns/1ps
`default_nettype none

module mips_alu (
	input  mips_pkg::alu_op_t op,
	input  logic [31:0]       a,
	input  logic [31:0]       b,
	input  logic [4:0]        shamt,
	output logic [31:0]       result,
	output logic              zero
);

	always_comb begin
		case (op)
			mips_pkg::ALU_ADD:  result = a + b; // No overflow trap
			mips_pkg::ALU_SUB:  result = a - b;
			mips_pkg::ALU_AND:  result = a & b;
			mips_pkg::ALU_OR:   result = a | b;
			mips_pkg::ALU_XOR:  result = a ^ b;
			mips_pkg::ALU_SLT:  result = {31'd0, $signed(a) < $signed(b)};
			mips_pkg::ALU_SLTU: result = {31'd0, a < b};
			mips_pkg::ALU_SLL:  result = b << shamt; // Shifts act on rt
			mips_pkg::ALU_SRL:  result = b >> shamt;
			mips_pkg::ALU_LUI:  result = {b[15:0], 16'h0000};
			default:            result = '0;
		endcase
	end

	// Equality rather than result==0, so BEQ/BNE need no SUB
	assign zero = (a == b);

endmodule

`default_nettype wire

// File: verilog/mips_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module mips_regfile (
	input  logic        clk,
	input  logic        reset,
	input  logic        write_en,
	input  logic [4:0]  read_addr_a,
	input  logic [4:0]  read_addr_b,
	input  logic [4:0]  write_addr,
	input  logic [31:0] write_data,
	output logic [31:0] read_data_a,
	output logic [31:0] read_data_b,
	output logic [31:0] v0
);

	logic [31:0] regs [32]; // GPR array

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (write_en && (write_addr != 5'd0)) begin // $0 never written
			regs[write_addr] <= write_data;
		end
	end

	assign read_data_a = regs[read_addr_a]; // Combinational reads
	assign read_data_b = regs[read_addr_b];
	assign v0          = regs[mips_pkg::V0_REG]; // Always visible

endmodule

`default_nettype wire

// File: verilog/mips_control.sv
`timescale 1ns/1ps
`default_nettype none

module mips_control (
	input  mips_pkg::instr_t instr,
	output mips_pkg::ctrl_t  ctrl
);

	always_comb begin
		ctrl = mips_pkg::CTRL_NOP; // Undefined codes fall through as no-op
		case (instr.op)
			mips_pkg::OP_SPECIAL: begin
				ctrl.reg_write = 1'b1; // Most R-types write rd
				ctrl.dst_rd    = 1'b1;
				case (instr.funct)
					mips_pkg::FN_ADDU: ctrl.alu_op = mips_pkg::ALU_ADD;
					mips_pkg::FN_SUBU: ctrl.alu_op = mips_pkg::ALU_SUB;
					mips_pkg::FN_AND:  ctrl.alu_op = mips_pkg::ALU_AND;
					mips_pkg::FN_OR:   ctrl.alu_op = mips_pkg::ALU_OR;
					mips_pkg::FN_XOR:  ctrl.alu_op = mips_pkg::ALU_XOR;
					mips_pkg::FN_SLT:  ctrl.alu_op = mips_pkg::ALU_SLT;
					mips_pkg::FN_SLTU: ctrl.alu_op = mips_pkg::ALU_SLTU;
					mips_pkg::FN_SLL:  ctrl.alu_op = mips_pkg::ALU_SLL; // Shift rt by shamt
					mips_pkg::FN_SRL:  ctrl.alu_op = mips_pkg::ALU_SRL;
					mips_pkg::FN_JR: begin
						ctrl.reg_write = 1'b0; // No link
						ctrl.jump_reg  = 1'b1;
					end
					mips_pkg::FN_JALR: begin
						ctrl.jump_reg = 1'b1;
						ctrl.wb_sel   = mips_pkg::WB_LINK; // Link into rd
					end
					default: ctrl = mips_pkg::CTRL_NOP; // Unknown funct
				endcase
			end
			mips_pkg::OP_ADDIU: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_imm   = 1'b1;
				ctrl.alu_op    = mips_pkg::ALU_ADD;
			end
			mips_pkg::OP_ANDI, mips_pkg::OP_ORI, mips_pkg::OP_XORI: begin
				ctrl.reg_write    = 1'b1;
				ctrl.alu_imm      = 1'b1;
				ctrl.imm_zero_ext = 1'b1; // Logic ops zero-extend
				ctrl.alu_op       = (instr.op == mips_pkg::OP_ANDI) ? mips_pkg::ALU_AND :
					(instr.op == mips_pkg::OP_ORI) ? mips_pkg::ALU_OR : mips_pkg::ALU_XOR;
			end
			mips_pkg::OP_SLTI, mips_pkg::OP_SLTIU: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_imm   = 1'b1; // Sign-extended even for SLTIU
				ctrl.alu_op    = (instr.op == mips_pkg::OP_SLTI) ? mips_pkg::ALU_SLT :
					mips_pkg::ALU_SLTU;
			end
			mips_pkg::OP_LUI: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_imm   = 1'b1;
				ctrl.alu_op    = mips_pkg::ALU_LUI;
			end
			mips_pkg::OP_LW: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_imm   = 1'b1; // Base plus offset
				ctrl.wb_sel    = mips_pkg::WB_MEM;
				ctrl.mem_read  = 1'b1;
			end
			mips_pkg::OP_SW: begin
				ctrl.alu_imm   = 1'b1;
				ctrl.mem_write = 1'b1;
			end
			mips_pkg::OP_BEQ: ctrl.branch_eq = 1'b1; // Uses ALU equal flag
			mips_pkg::OP_BNE: ctrl.branch_ne = 1'b1;
			mips_pkg::OP_J:   ctrl.jump      = 1'b1;
			mips_pkg::OP_JAL: begin
				ctrl.jump      = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.dst_link  = 1'b1; // Link into $31
				ctrl.wb_sel    = mips_pkg::WB_LINK;
			end
			default: ctrl = mips_pkg::CTRL_NOP;
		endcase
	end

endmodule

`default_nettype wire

// File: verilog/mips_pkg.sv
`default_nettype none

package mips_pkg;

	typedef enum logic [5:0] {
		OP_SPECIAL = 6'b000000, // R-type, decoded further by funct
		OP_J       = 6'b000010,
		OP_JAL     = 6'b000011,
		OP_BEQ     = 6'b000100,
		OP_BNE     = 6'b000101,
		OP_ADDIU   = 6'b001001,
		OP_SLTI    = 6'b001010,
		OP_SLTIU   = 6'b001011,
		OP_ANDI    = 6'b001100,
		OP_ORI     = 6'b001101,
		OP_XORI    = 6'b001110,
		OP_LUI     = 6'b001111,
		OP_LW      = 6'b100011,
		OP_SW      = 6'b101011
	} opcode_t;

	typedef enum logic [5:0] {
		FN_SLL  = 6'b000000,
		FN_SRL  = 6'b000010,
		FN_JR   = 6'b001000,
		FN_JALR = 6'b001001,
		FN_ADDU = 6'b100001,
		FN_SUBU = 6'b100011,
		FN_AND  = 6'b100100,
		FN_OR   = 6'b100101,
		FN_XOR  = 6'b100110,
		FN_SLT  = 6'b101010,
		FN_SLTU = 6'b101011
	} funct_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLTU,
		ALU_SLL,
		ALU_SRL,
		ALU_LUI
	} alu_op_t;

	typedef enum logic [1:0] {
		WB_ALU,  // ALU result
		WB_MEM,  // Loaded word
		WB_LINK  // Return address
	} wb_sel_t;

	typedef struct packed {
		opcode_t    op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		funct_t     funct;
	} instr_t;

	typedef struct packed {
		logic    reg_write;
		logic    dst_rd;       // Destination rd, else rt
		logic    dst_link;     // Destination $31
		logic    alu_imm;      // Operand B from immediate
		logic    imm_zero_ext; // Logic immediates
		alu_op_t alu_op;
		wb_sel_t wb_sel;
		logic    mem_read;
		logic    mem_write;
		logic    branch_eq;
		logic    branch_ne;
		logic    jump;         // 26-bit target
		logic    jump_reg;     // Target from rs
	} ctrl_t;

	localparam ctrl_t CTRL_NOP = '{alu_op: ALU_ADD, wb_sel: WB_ALU, default: 1'b0};

	localparam logic [31:0] RESET_VECTOR = 32'hBFC00000;
	localparam logic [4:0]  LINK_REG     = 5'd31;
	localparam logic [4:0]  V0_REG       = 5'd2;

endpackage

`default_nettype wire
